/* design/busPkg.sv */
// Address map, widths and region codes for the dual 6809 bus glue
// Main control register addresses and sub latch windows

package busPkg;

	//************************************************************
	// Widths
	//************************************************************
	localparam int addrW    = 16; // Both CPUs
	localparam int dataW    = 8;
	localparam int ramAddrW = 13; // 8K shared work RAM
	localparam int abW      = 15; // Buffered main address bus

	localparam logic [dataW-1:0] idleData = 8'hFF; // Stands in for a floating bus

	//************************************************************
	// Main CPU regions
	//************************************************************
	typedef enum logic [2:0] {
		shared = 3'd0, // 0000-1FFF work RAM
		map    = 3'd1, // 2000-27FF
		back1  = 3'd2, // 2800-2FFF
		back2  = 3'd3, // 3000-37FF
		obj    = 3'd4, // 3800-39FF
		io     = 3'd5, // 3A00-3BFF
		pal    = 3'd6, // 3C00-3FFF
		none   = 3'd7  // 4000 and up
	} region;

	// Main control writes inside the io window
	localparam logic [addrW-1:0] nmiClearAddr  = 16'h3A09;
	localparam logic [addrW-1:0] firqClearAddr = 16'h3A0A;
	localparam logic [addrW-1:0] irqClearAddr  = 16'h3A0B;
	localparam logic [addrW-1:0] subIrqSetAddr = 16'h3A0C;

	//************************************************************
	// Sub CPU latch windows, 2K each
	//************************************************************
	localparam int subWinLsb = 11; // Lowest address bit that selects a window
	localparam logic [addrW-1:0] subMainIrqAddr  = 16'h2000; // Raises main IRQ
	localparam logic [addrW-1:0] subIrqClearAddr = 16'h2800; // Drops sub IRQ
	localparam logic [addrW-1:0] subBankAddr     = 16'h3000; // ROM bank from D0

endpackage

/* design/mainDecode.sv */
// Main CPU address decoder
// Region classification, start pulses, buffered address bus and chip selects
`timescale 1ns/1ns

module mainDecode (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     mainStrobe,
	input  logic [busPkg::addrW-1:0] mainAddr,
	input  logic                     mainRw,
	output busPkg::region            mainRegion,
	output logic                     mainStart,
	output logic                     mainWriteStart,
	output logic [busPkg::abW-1:0]   ab,
	output logic                     rw,
	output logic                     mapSelN,
	output logic                     back1SelN,
	output logic                     back2SelN,
	output logic                     objSelN,
	output logic                     ioN,
	output logic                     plSelN
);

	logic       strobePrev;
	logic [5:0] selNext; // pal io obj back2 back1 map, active low
	logic [5:0] selN;

	// Same split as the 138 and 139 pair on the board
	always_comb begin
		if (mainAddr[15:14] != 2'b00)
			mainRegion = busPkg::none; // ROM space
		else if (!mainAddr[13])
			mainRegion = busPkg::shared;
		else begin
			case (mainAddr[12:11])
				2'b00:   mainRegion = busPkg::map;
				2'b01:   mainRegion = busPkg::back1;
				2'b10:   mainRegion = busPkg::back2;
				default: begin
					case (mainAddr[10:9]) // 3800-3FFF split further
						2'b00:   mainRegion = busPkg::obj;
						2'b01:   mainRegion = busPkg::io;
						default: mainRegion = busPkg::pal; // 3C00-3FFF
					endcase
				end
			endcase
		end
	end

	always_comb begin
		selNext = '1;
		case (mainRegion)
			busPkg::map:   selNext[0] = 1'b0;
			busPkg::back1: selNext[1] = 1'b0;
			busPkg::back2: selNext[2] = 1'b0;
			busPkg::obj:   selNext[3] = 1'b0;
			busPkg::io:    selNext[4] = 1'b0;
			busPkg::pal:   selNext[5] = 1'b0;
			default:       selNext = '1; // RAM and ROM have no select here
		endcase
	end

	//************************************************************
	// Registered bus side
	//************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			strobePrev     <= 1'b0;
			mainStart      <= 1'b0;
			mainWriteStart <= 1'b0;
			selN           <= '1;
			rw             <= 1'b1;
		end else begin
			strobePrev     <= mainStrobe;
			mainStart      <= mainStrobe & ~strobePrev; // One clock per cycle
			mainWriteStart <= mainStrobe & ~strobePrev & ~mainRw;
			selN           <= mainStrobe ? selNext : '1; // Held while strobed
			if (mainStrobe)
				rw <= mainRw;
		end
	end

	always_ff @(posedge clk) begin
		if (mainStrobe)
			ab <= mainAddr[busPkg::abW-1:0]; // A15 never leaves the board
	end

	assign {plSelN, ioN, objSelN, back2SelN, back1SelN, mapSelN} = selN;

endmodule

/* design/subDecode.sv */
// Sub CPU address decoder
// Shared RAM select and write pulses for the three sub latches
`timescale 1ns/1ns

module subDecode (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     subStrobe,
	input  logic [busPkg::addrW-1:0] subAddr,
	input  logic                     subRw,
	input  logic [busPkg::dataW-1:0] subWriteData,
	output logic                     subRamSel,
	output logic                     subStart,
	output logic                     mainIrqSet,
	output logic                     subIrqClear,
	output logic                     bankLoad,
	output logic                     bankBit
);

	localparam int hi = busPkg::addrW - 1;
	localparam int lo = busPkg::subWinLsb;

	logic strobePrev;
	logic startNext;
	logic writeStart; // First clock of a sub write

	assign subRamSel  = (subAddr[hi:busPkg::ramAddrW] == '0); // Below 2000
	assign startNext  = subStrobe & ~strobePrev;
	assign writeStart = startNext & ~subRw;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobePrev  <= 1'b0;
			subStart    <= 1'b0;
			mainIrqSet  <= 1'b0;
			subIrqClear <= 1'b0;
			bankLoad    <= 1'b0;
		end else begin
			strobePrev  <= subStrobe;
			subStart    <= startNext;
			mainIrqSet  <= writeStart & (subAddr[hi:lo] == busPkg::subMainIrqAddr[hi:lo]);
			subIrqClear <= writeStart & (subAddr[hi:lo] == busPkg::subIrqClearAddr[hi:lo]);
			bankLoad    <= writeStart & (subAddr[hi:lo] == busPkg::subBankAddr[hi:lo]);
		end
	end

	always_ff @(posedge clk) begin
		if (writeStart)
			bankBit <= subWriteData[0]; // Travels with bankLoad
	end

endmodule

/* design/controlLatches.sv */
// Interrupt request flip-flops for both CPUs
// Sub ROM bank register
`timescale 1ns/1ns

module controlLatches (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     vblank,
	input  logic                     ims,
	input  busPkg::region            mainRegion,
	input  logic                     mainWriteStart,
	input  logic [busPkg::addrW-1:0] mainAddr,
	input  logic                     mainIrqSet,
	input  logic                     subIrqClear,
	input  logic                     bankLoad,
	input  logic                     bankBit,
	output logic                     nmiN,
	output logic                     irqN,
	output logic                     firqN,
	output logic                     subIrqN,
	output logic                     subBank
);

	logic vblankD1, vblankD2;
	logic imsD1, imsD2;
	logic vblankRise, imsRise;
	logic ctrlWrite; // Main write into the io window
	logic nmiClear, firqClear, irqClear, subIrqSet;
	logic nmiReq, firqReq, irqReq, subIrqReq;

	assign vblankRise = vblankD1 & ~vblankD2;
	assign imsRise    = imsD1 & ~imsD2;

	assign ctrlWrite = mainWriteStart & (mainRegion == busPkg::io);
	assign nmiClear  = ctrlWrite & (mainAddr == busPkg::nmiClearAddr);
	assign firqClear = ctrlWrite & (mainAddr == busPkg::firqClearAddr);
	assign irqClear  = ctrlWrite & (mainAddr == busPkg::irqClearAddr);
	assign subIrqSet = ctrlWrite & (mainAddr == busPkg::subIrqSetAddr);

	//************************************************************
	// Request flops, clear beats set
	//************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			{vblankD1, vblankD2, imsD1, imsD2} <= '0;
			{nmiReq, firqReq, irqReq, subIrqReq} <= '0;
			subBank <= 1'b0;
		end else begin
			vblankD1 <= vblank;
			vblankD2 <= vblankD1;
			imsD1    <= ims;
			imsD2    <= imsD1;
			if (nmiClear) nmiReq <= 1'b0;
			else if (vblankRise) nmiReq <= 1'b1; // Frame interrupt
			if (firqClear) firqReq <= 1'b0;
			else if (imsRise) firqReq <= 1'b1;
			if (irqClear) irqReq <= 1'b0;
			else if (mainIrqSet) irqReq <= 1'b1; // Raised by sub CPU
			if (subIrqClear) subIrqReq <= 1'b0;
			else if (subIrqSet) subIrqReq <= 1'b1; // Raised by main CPU
			if (bankLoad)
				subBank <= bankBit;
		end
	end

	assign nmiN    = ~nmiReq;
	assign firqN   = ~firqReq;
	assign irqN    = ~irqReq;
	assign subIrqN = ~subIrqReq;

endmodule

/* design/sharedRamArbiter.sv */
// Shared 8K work RAM with alternating main and sub slots
// Read returns routed back to the side that was served
`timescale 1ns/1ns

module sharedRamArbiter (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     mainStrobe,
	input  busPkg::region            mainRegion,
	input  logic                     mainStart,
	input  logic [busPkg::addrW-1:0] mainAddr,
	input  logic                     mainRw,
	input  logic [busPkg::dataW-1:0] mainWriteData,
	input  logic                     subStrobe,
	input  logic                     subRamSel,
	input  logic                     subStart,
	input  logic [busPkg::addrW-1:0] subAddr,
	input  logic                     subRw,
	input  logic [busPkg::dataW-1:0] subWriteData,
	output logic [busPkg::dataW-1:0] mainRamData,
	output logic                     mainRamValid,
	output logic [busPkg::dataW-1:0] subReadData,
	output logic                     subReadValid
);

	localparam int depth = 1 << busPkg::ramAddrW;

	logic                        slotSub;    // Low on main slot
	logic                        mainServed; // Already served in this cycle
	logic                        subServed;
	logic                        mainHit;
	logic                        subHit;
	logic                        mainReadPend;
	logic                        subReadPend;
	logic                        ramWe;
	logic [busPkg::ramAddrW-1:0] ramAddr;
	logic [busPkg::dataW-1:0]    ramWData;
	logic [busPkg::dataW-1:0]    ramQ;
	logic [busPkg::dataW-1:0]    mem [0:depth-1];

	// At most one side owns the RAM port in any clock
	assign mainHit  = mainStrobe & (mainRegion == busPkg::shared) & ~slotSub & ~mainServed;
	assign subHit   = subStrobe & subRamSel & slotSub & ~subServed;
	assign ramAddr  = slotSub ? subAddr[busPkg::ramAddrW-1:0] : mainAddr[busPkg::ramAddrW-1:0];
	assign ramWData = slotSub ? subWriteData : mainWriteData;
	assign ramWe    = (mainHit & ~mainRw) | (subHit & ~subRw);

	initial begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0; // Work RAM starts cleared
	end

	//************************************************************
	// RAM array, synchronous read
	//************************************************************
	always_ff @(posedge clk) begin
		if (ramWe)
			mem[ramAddr] <= ramWData;
		ramQ <= mem[ramAddr];
	end

	//************************************************************
	// Slot, served flags and return valids
	//************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			slotSub      <= 1'b0; // Main owns the first slot
			mainServed   <= 1'b0;
			subServed    <= 1'b0;
			mainReadPend <= 1'b0;
			subReadPend  <= 1'b0;
			mainRamValid <= 1'b0;
			subReadValid <= 1'b0;
		end else begin
			slotSub <= ~slotSub;
			if (mainStart) mainServed <= 1'b0; // Window ends after this clock
			else if (mainHit) mainServed <= 1'b1;
			if (subStart) subServed <= 1'b0;
			else if (subHit) subServed <= 1'b1;
			mainReadPend <= mainHit & mainRw;
			subReadPend  <= subHit & subRw;
			mainRamValid <= mainReadPend; // Data out of ramQ this clock
			subReadValid <= subReadPend;
		end
	end

	always_ff @(posedge clk) begin
		if (mainReadPend)
			mainRamData <= ramQ;
		if (subReadPend)
			subReadData <= ramQ;
	end

endmodule

/* design/mainBusPort.sv */
// Main CPU read return merge and external data bus output
`timescale 1ns/1ns

module mainBusPort (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     mainStart,
	input  busPkg::region            mainRegion,
	input  logic                     mainRw,
	input  logic [busPkg::dataW-1:0] mainWriteData,
	input  logic [busPkg::dataW-1:0] mainRamData,
	input  logic                     mainRamValid,
	input  logic [busPkg::dataW-1:0] dbIn,
	output logic [busPkg::dataW-1:0] mainReadData,
	output logic                     mainReadValid,
	output logic [busPkg::dataW-1:0] dbOut
);

	logic                     extRegion; // map through pal
	logic                     extValid;
	logic [busPkg::dataW-1:0] extData;

	assign extRegion = (mainRegion != busPkg::shared) && (mainRegion != busPkg::none);

	// Non RAM reads answer one clock after start
	always_ff @(posedge clk) begin
		if (reset)
			extValid <= 1'b0;
		else
			extValid <= mainStart & mainRw & (mainRegion != busPkg::shared);
	end

	always_ff @(posedge clk) begin
		if (mainStart)
			extData <= extRegion ? dbIn : busPkg::idleData; // ROM space floats
	end

	// RAM and external returns never overlap
	assign mainReadValid = mainRamValid | extValid;
	assign mainReadData  = mainRamValid ? mainRamData : extData;

	// Write data driven out only toward the video and io boards
	assign dbOut = (mainStart & ~mainRw & extRegion) ? mainWriteData : busPkg::idleData;

endmodule

/* design/cpuBusTop.sv */
// Bus glue top for the main and sub 6809 CPUs
// Decoders, control latches, shared RAM arbiter and main bus port
`timescale 1ns/1ns

module cpuBusTop (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     vblank,
	input  logic                     ims,
	input  logic [busPkg::dataW-1:0] dbIn,
	// Main CPU bus
	input  logic                     mainStrobe,
	input  logic [busPkg::addrW-1:0] mainAddr,
	input  logic                     mainRw,
	input  logic [busPkg::dataW-1:0] mainWriteData,
	// Sub CPU bus
	input  logic                     subStrobe,
	input  logic [busPkg::addrW-1:0] subAddr,
	input  logic                     subRw,
	input  logic [busPkg::dataW-1:0] subWriteData,
	// Board side
	output logic [busPkg::abW-1:0]   ab,
	output logic                     rw,
	output logic                     mapSelN,
	output logic                     back1SelN,
	output logic                     back2SelN,
	output logic                     objSelN,
	output logic                     ioN,
	output logic                     plSelN,
	output logic [busPkg::dataW-1:0] dbOut,
	// Read returns
	output logic [busPkg::dataW-1:0] mainReadData,
	output logic                     mainReadValid,
	output logic [busPkg::dataW-1:0] subReadData,
	output logic                     subReadValid,
	// Interrupts and bank
	output logic                     nmiN,
	output logic                     irqN,
	output logic                     firqN,
	output logic                     subIrqN,
	output logic                     subBank
);

	busPkg::region            mainRegion;
	logic                     mainStart;
	logic                     mainWriteStart;
	logic                     subRamSel;
	logic                     subStart;
	logic                     mainIrqSet;  // Sub to main IRQ
	logic                     subIrqClear;
	logic                     bankLoad;
	logic                     bankBit;
	logic [busPkg::dataW-1:0] mainRamData;
	logic                     mainRamValid;

	// All ports connect by matching names
	mainDecode       i_mainDecode       (.*);
	subDecode        i_subDecode        (.*);
	controlLatches   i_controlLatches   (.*);
	sharedRamArbiter i_sharedRamArbiter (.*);
	mainBusPort      i_mainBusPort      (.*);

endmodule

/* verif/clockGen.sv */
// Testbench clock and synchronous reset source
`timescale 1ns/1ns

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk); // Two reset edges
		@(negedge clk) reset = 1'b0;
	end

endmodule

/* verif/busChecker.sv */
// Reference model of the bus glue and comparing monitor
// Region table, slot ordered shared RAM, interrupt latches and bank
`timescale 1ns/1ns

module busChecker (
	input  logic        clk,
	input  logic        reset,
	input  logic        vblank,
	input  logic        ims,
	input  logic [7:0]  dbIn,
	input  logic        mainStrobe,
	input  logic [15:0] mainAddr,
	input  logic        mainRw,
	input  logic [7:0]  mainWriteData,
	input  logic        subStrobe,
	input  logic [15:0] subAddr,
	input  logic        subRw,
	input  logic [7:0]  subWriteData,
	input  logic [14:0] ab,
	input  logic        rw,
	input  logic        mapSelN,
	input  logic        back1SelN,
	input  logic        back2SelN,
	input  logic        objSelN,
	input  logic        ioN,
	input  logic        plSelN,
	input  logic [7:0]  dbOut,
	input  logic [7:0]  mainReadData,
	input  logic        mainReadValid,
	input  logic [7:0]  subReadData,
	input  logic        subReadValid,
	input  logic        nmiN,
	input  logic        irqN,
	input  logic        firqN,
	input  logic        subIrqN,
	input  logic        subBank,
	output int          errorCount,
	output int          checkCount,
	output int          pendingCount
);

	logic [7:0]  mem [0:8191]; // Model of the work RAM
	int          cycle;
	bit          armed;        // Seen a reset edge
	bit          slotSub;
	bit          mainPrev, subPrev;
	bit          mainWasStart, subWasStart; // Last edge was a strobe rise
	logic [5:0]  expSel;       // pal io obj back2 back1 map
	logic [14:0] expAb;
	logic        expRw;
	bit          expAbValid;
	bit          nmiReq, firqReq, irqReq, subIrqReq, bank;
	bit          vD1, vD2, iD1, iD2;
	int          mainDue[$];
	logic [7:0]  mainData[$];
	int          subDue[$];
	logic [7:0]  subData[$];

	initial begin
		errorCount   = 0;
		checkCount   = 0;
		pendingCount = 0;
		cycle        = 0;
		armed        = 0;
		for (int i = 0; i < 8192; i++)
			mem[i] = 8'h00;
	end

	//************************************************************
	// Reference tables
	//************************************************************
	function automatic int regionOf(logic [15:0] a);
		if (a >= 16'h4000) return 7; // none
		if (a <  16'h2000) return 0; // shared
		if (a <  16'h2800) return 1; // map
		if (a <  16'h3000) return 2;
		if (a <  16'h3800) return 3;
		if (a <  16'h3A00) return 4; // obj
		if (a <  16'h3C00) return 5; // io
		return 6;                    // pal
	endfunction

	function automatic logic [5:0] selFor(int r);
		logic [5:0] s;
		s = 6'h3F;
		if (r >= 1 && r <= 6)
			s[r-1] = 1'b0;
		return s;
	endfunction

	task automatic showMismatch(string name, logic [15:0] expV, logic [15:0] actV);
		errorCount++;
		$display("Mismatch %s: expected %h, actual %h at cycle %0d", name, expV, actV, cycle);
	endtask

	task automatic noteFailure(string msg);
		errorCount++;
		$display("Error at cycle %0d: %s", cycle, msg);
	endtask

	task automatic compareBit(string name, logic expV, logic actV);
		checkCount++;
		if (actV !== expV)
			showMismatch(name, {15'd0, expV}, {15'd0, actV});
	endtask

	//************************************************************
	// Compare, then advance the model
	//************************************************************
	always @(posedge clk) begin
		int         mReg;
		logic [5:0] obsSel;
		logic [7:0] expDb;
		bit         subWin1, subWin2, subWin3;
		bit         vRise, iRise;

		cycle++;
		mReg = regionOf(mainAddr);
		if (armed && !reset) begin
			obsSel = {plSelN, ioN, objSelN, back2SelN, back1SelN, mapSelN};
			checkCount++;
			if (obsSel !== expSel)
				showMismatch("selN", {10'd0, expSel}, {10'd0, obsSel});
			if (expAbValid) begin
				checkCount++;
				if (ab !== expAb)
					showMismatch("ab", {1'b0, expAb}, {1'b0, ab});
				compareBit("rw", expRw, rw);
			end
			// Write data only toward map through pal
			expDb = (mainWasStart && !mainRw && mReg >= 1 && mReg <= 6) ? mainWriteData : 8'hFF;
			checkCount++;
			if (dbOut !== expDb)
				showMismatch("dbOut", {8'd0, expDb}, {8'd0, dbOut});
			compareBit("nmiN", ~nmiReq, nmiN);
			compareBit("firqN", ~firqReq, firqN);
			compareBit("irqN", ~irqReq, irqN);
			compareBit("subIrqN", ~subIrqReq, subIrqN);
			compareBit("subBank", bank, subBank);

			// Main read returns
			if (mainReadValid === 1'b1) begin
				checkCount++;
				if (mainDue.size() == 0 || mainDue[0] != cycle)
					noteFailure("main read valid pulsed with no read due");
				else begin
					if (mainReadData !== mainData[0])
						showMismatch("mainReadData", {8'd0, mainData[0]}, {8'd0, mainReadData});
					void'(mainDue.pop_front());
					void'(mainData.pop_front());
				end
			end else if (mainReadValid !== 1'b0)
				noteFailure("main read valid is unknown");
			while (mainDue.size() != 0 && mainDue[0] <= cycle) begin
				noteFailure("main read valid missing for a read");
				void'(mainDue.pop_front());
				void'(mainData.pop_front());
			end

			// Sub read returns
			if (subReadValid === 1'b1) begin
				checkCount++;
				if (subDue.size() == 0 || subDue[0] != cycle)
					noteFailure("sub read valid pulsed with no read due");
				else begin
					if (subReadData !== subData[0])
						showMismatch("subReadData", {8'd0, subData[0]}, {8'd0, subReadData});
					void'(subDue.pop_front());
					void'(subData.pop_front());
				end
			end else if (subReadValid !== 1'b0)
				noteFailure("sub read valid is unknown");
			while (subDue.size() != 0 && subDue[0] <= cycle) begin
				noteFailure("sub read valid missing for a read");
				void'(subDue.pop_front());
				void'(subData.pop_front());
			end
		end

		if (reset) begin
			armed        = 1;
			slotSub      = 0; // Main slot first
			expSel       = 6'h3F;
			expAbValid   = 0;
			{nmiReq, firqReq, irqReq, subIrqReq, bank} = '0;
			{vD1, vD2, iD1, iD2} = '0;
			{mainPrev, subPrev, mainWasStart, subWasStart} = '0;
			mainDue.delete();
			mainData.delete();
			subDue.delete();
			subData.delete();
		end else if (armed) begin
			// Latch windows of the sub CPU, 2K each
			subWin1 = subAddr >= 16'h2000 && subAddr < 16'h2800;
			subWin2 = subAddr >= 16'h2800 && subAddr < 16'h3000;
			subWin3 = subAddr >= 16'h3000 && subAddr < 16'h3800;
			vRise   = vD1 && !vD2;
			iRise   = iD1 && !iD2;

			if (mainWasStart && !mainRw && mainAddr == 16'h3A09) nmiReq = 0;
			else if (vRise) nmiReq = 1;
			if (mainWasStart && !mainRw && mainAddr == 16'h3A0A) firqReq = 0;
			else if (iRise) firqReq = 1;
			if (mainWasStart && !mainRw && mainAddr == 16'h3A0B) irqReq = 0;
			else if (subWasStart && !subRw && subWin1) irqReq = 1;
			if (subWasStart && !subRw && subWin2) subIrqReq = 0; // Clear wins
			else if (mainWasStart && !mainRw && mainAddr == 16'h3A0C) subIrqReq = 1;
			if (subWasStart && !subRw && subWin3)
				bank = subWriteData[0];
			vD2 = vD1;
			vD1 = vblank;
			iD2 = iD1;
			iD1 = ims;

			// Non RAM main reads answer on the next clock
			if (mainWasStart && mainRw && mReg != 0) begin
				mainDue.push_back(cycle + 1);
				mainData.push_back(mReg == 7 ? 8'hFF : dbIn);
			end

			// Slot owner touches the RAM
			if (!slotSub && mainStrobe && mReg == 0) begin
				if (mainRw) begin
					mainDue.push_back(cycle + 2);
					mainData.push_back(mem[mainAddr[12:0]]);
				end else
					mem[mainAddr[12:0]] = mainWriteData;
			end
			if (slotSub && subStrobe && subAddr < 16'h2000) begin
				if (subRw) begin
					subDue.push_back(cycle + 2);
					subData.push_back(mem[subAddr[12:0]]);
				end else
					mem[subAddr[12:0]] = subWriteData;
			end

			expSel = mainStrobe ? selFor(mReg) : 6'h3F;
			if (mainStrobe) begin
				expAb      = mainAddr[14:0];
				expRw      = mainRw;
				expAbValid = 1;
			end
			slotSub      = !slotSub;
			mainWasStart = mainStrobe && !mainPrev;
			mainPrev     = mainStrobe;
			subWasStart  = subStrobe && !subPrev;
			subPrev      = subStrobe;
		end
		pendingCount = mainDue.size() + subDue.size();
	end

endmodule

/* verif/cpuBus_properties.sv */
// Concurrent checks bound into the bus glue top
// Valid after strobe, one main select, outputs after reset
`timescale 1ns/1ns

module cpuBus_properties (
	input logic clk,
	input logic reset,
	input logic mainStrobe,
	input logic subStrobe,
	input logic mainReadValid,
	input logic subReadValid,
	input logic mapSelN,
	input logic back1SelN,
	input logic back2SelN,
	input logic objSelN,
	input logic ioN,
	input logic plSelN,
	input logic nmiN,
	input logic irqN,
	input logic firqN,
	input logic subIrqN,
	input logic subBank
);

	// Every return was preceded by a strobed clock
	assert property (@(posedge clk) disable iff (reset) mainReadValid |-> $past(mainStrobe, 2))
		else $error("main read valid without a preceding strobe");
	assert property (@(posedge clk) disable iff (reset) subReadValid |-> $past(subStrobe, 2))
		else $error("sub read valid without a preceding strobe");

	assert property (@(posedge clk) disable iff (reset)
		$onehot0(~{mapSelN, back1SelN, back2SelN, objSelN, ioN, plSelN}))
		else $error("more than one main chip select low");

	assert property (@(posedge clk) reset |=> (nmiN && irqN && firqN && subIrqN && !subBank
		&& !mainReadValid && !subReadValid))
		else $error("outputs not inactive after reset");

endmodule

bind cpuBusTop cpuBus_properties props (.*);

/* verif/tbTop.sv */
// Testbench top with DUT, random bus traffic and run limit
// Final report with check and error counts
`timescale 1ns/1ns

module tbTop;

	localparam int timeoutLimit = 400 * 4 + 200;

	logic        clk, reset;
	logic        vblank, ims;
	logic [7:0]  dbIn;
	logic        mainStrobe, mainRw, subStrobe, subRw;
	logic [15:0] mainAddr, subAddr;
	logic [7:0]  mainWriteData, subWriteData;
	logic [14:0] ab;
	logic        rw, mapSelN, back1SelN, back2SelN, objSelN, ioN, plSelN;
	logic [7:0]  dbOut, mainReadData, subReadData;
	logic        mainReadValid, subReadValid;
	logic        nmiN, irqN, firqN, subIrqN, subBank;
	int          errorCount, checkCount, pendingCount;
	int          cycleCount;
	bit          trafficDone;

	clockGen   clocks (.clk(clk), .reset(reset));
	cpuBusTop  i_cpuBusTop (.*);
	busChecker monitor (.*);

	// Mix of RAM hot spots, devices, control registers and ROM space
	function automatic logic [15:0] pickMainAddr();
		case ($urandom % 8)
			0, 1, 2: return 16'($urandom % 32); // Shared with the sub CPU
			3:       return 16'($urandom % 16'h2000);
			4:       return 16'h2000 + 16'($urandom % 16'h2000);
			5:       return 16'h3A09 + 16'($urandom % 4);
			6:       return 16'h3800 + 16'($urandom % 16'h800);
			default: return 16'h4000 + 16'($urandom % 16'hC000);
		endcase
	endfunction

	function automatic logic [15:0] pickSubAddr();
		case ($urandom % 8)
			0, 1, 2, 3: return 16'($urandom % 32);
			4:          return 16'h2000 + 16'($urandom % 16'h800);
			5:          return 16'h2800 + 16'($urandom % 16'h800);
			6:          return 16'h3000 + 16'($urandom % 16'h800);
			default:    return 16'h3800 + 16'($urandom % 16'hC800);
		endcase
	endfunction

	//************************************************************
	// Bus cycles, two strobed clocks then idle
	//************************************************************
	task automatic runMainTraffic();
		repeat (400) begin
			@(negedge clk);
			mainStrobe    = 1'b1;
			mainAddr      = pickMainAddr();
			mainRw        = $urandom % 2;
			mainWriteData = $urandom;
			repeat (2) @(negedge clk);
			mainStrobe = 1'b0;
			mainAddr   = $urandom; // Junk while idle
			mainRw     = $urandom % 2;
			if ($urandom % 2)
				@(negedge clk);
		end
	endtask

	task automatic runSubTraffic();
		repeat (400) begin
			@(negedge clk);
			subStrobe    = 1'b1;
			subAddr      = pickSubAddr();
			subRw        = $urandom % 2;
			subWriteData = $urandom;
			repeat (2) @(negedge clk);
			subStrobe = 1'b0;
			subAddr   = $urandom;
			subRw     = $urandom % 2;
			if ($urandom % 2)
				@(negedge clk);
		end
	endtask

	task automatic driveLineNoise();
		while (!trafficDone) begin
			@(negedge clk);
			dbIn = $urandom;
			if ($urandom % 8 == 0) vblank = ~vblank; // Occasional edges
			if ($urandom % 8 == 0) ims = ~ims;
		end
	endtask

	initial begin
		mainStrobe    = 1'b0;
		mainAddr      = '0;
		mainRw        = 1'b1;
		mainWriteData = '0;
		subStrobe     = 1'b0;
		subAddr       = '0;
		subRw         = 1'b1;
		subWriteData  = '0;
		vblank        = 1'b0;
		ims           = 1'b0;
		dbIn          = '0;
		trafficDone   = 1'b0;
		void'($urandom(92));
		@(negedge reset);
		fork
			begin
				fork
					runMainTraffic();
					runSubTraffic();
				join
				trafficDone = 1'b1;
			end
			driveLineNoise();
		join
		repeat (8) @(negedge clk); // Let returns drain
		if (pendingCount != 0)
			$display("Error: %0d reads never returned data", pendingCount);
		$display("Checks %0d, errors %0d, reads outstanding %0d",
			checkCount, errorCount, pendingCount);
		if (errorCount == 0 && pendingCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Run limit in clocks
	initial cycleCount = 0;
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout: traffic did not finish within %0d clocks", timeoutLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

/* xsleenaBus.f */
design/busPkg.sv
design/mainDecode.sv
design/subDecode.sv
design/controlLatches.sv
design/sharedRamArbiter.sv
design/mainBusPort.sv
design/cpuBusTop.sv
verif/clockGen.sv
verif/busChecker.sv
verif/cpuBus_properties.sv
verif/tbTop.sv

/* Bender.yml */
package:
  name: xsleenaBus

sources:
  - files:
      - design/busPkg.sv
      - design/mainDecode.sv
      - design/subDecode.sv
      - design/controlLatches.sv
      - design/sharedRamArbiter.sv
      - design/mainBusPort.sv
      - design/cpuBusTop.sv
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/busChecker.sv
      - verif/cpuBus_properties.sv
      - verif/tbTop.sv
